//--- include/dac_macros.svh
`ifndef DAC_MACROS_SVH
`define DAC_MACROS_SVH

// Number of channel controllers behind the decoder
`define DAC_NUM_CHANNELS 4

// Upper address byte that selects this controller
`define DAC_POSITION 8'd240

// Register offsets inside the address window
`define DAC_REG_ID 8'd9
`define DAC_REG_BUSY 8'd10
`define DAC_REG_LAST_BASE 8'd16

// Identification value returned at DAC_REG_ID
`define DAC_ID_WORD 16'h0DAC

// Serial frame length in bits
`define DAC_FRAME_BITS 16

`endif

//--- rtl/dac_pkg.sv
`default_nettype none

`include "dac_macros.svh"

package dac_pkg;

  // Opcode carried in the upper half of a host write
  typedef enum logic [15:0] {
    NOP       = 16'd0,
    NEW_VALUE = 16'd1
  } dac_cmd_e;

  // Channel framing states, one-hot
  typedef enum logic [2:0] {
    IDLE  = 3'b001,
    SHIFT = 3'b010,
    LDAC  = 3'b100
  } dac_state_e;

  // One DAC code, one frame worth of bits
  typedef logic [`DAC_FRAME_BITS-1:0] dac_code_t;

endpackage

`default_nettype wire

//--- rtl/dac_chan_if.sv
`default_nettype none

interface dac_chan_if
  import dac_pkg::*;
();

  // One-cycle strobe from the decoder
  logic      load;
  // Code that goes with the strobe
  dac_code_t code;
  // Channel has a frame queued or in flight
  logic      busy;
  // Code of the last completed frame
  dac_code_t last_code;

  modport dec (
    output load,
    output code
  );

  modport chan (
    input  load,
    input  code,
    output busy,
    output last_code
  );

  // Read side for the readback mux
  modport mon (
    input busy,
    input last_code
  );

endinterface

`default_nettype wire

//--- rtl/cmd_decoder.sv
`default_nettype none

`include "dac_macros.svh"

module cmd_decoder
  import dac_pkg::*;
(
  input  wire logic        sclk,
  input  wire logic        reset,
  input  wire logic        cmd_bus_enable,
  input  wire logic        cmd_bus_wr,
  input  wire logic [15:0] cmd_bus_addr,
  input  wire logic [31:0] cmd_bus_data,
  dac_chan_if.dec          chan [`DAC_NUM_CHANNELS]
);

  logic                         window_hit;
  logic                         chan_in_range;
  logic                         new_value;
  logic                         write_hit;
  logic [7:0]                   chan_index;
  logic [`DAC_NUM_CHANNELS-1:0] chan_sel;
  dac_cmd_e                     opcode;
  dac_code_t                    write_code;

  // Controller select on the upper address byte
  assign window_hit = cmd_bus_enable && (cmd_bus_addr[15:8] == `DAC_POSITION);

  // Low byte picks the channel register
  assign chan_index    = cmd_bus_addr[7:0];
  assign chan_in_range = (chan_index < 8'(`DAC_NUM_CHANNELS));

  assign opcode     = dac_cmd_e'(cmd_bus_data[31:16]);
  assign write_code = dac_code_t'(cmd_bus_data[15:0]);

  // Only NEW_VALUE starts a transfer
  always_comb begin
    case (opcode)
      NEW_VALUE: new_value = 1'b1;
      default:   new_value = 1'b0;
    endcase
  end

  assign write_hit = window_hit && cmd_bus_wr && chan_in_range && new_value;

  // One-hot channel select for this write
  always_comb begin
    chan_sel = '0;
    for (int i = 0; i < `DAC_NUM_CHANNELS; i++) begin
      if (write_hit && (chan_index == 8'(i))) begin
        chan_sel[i] = 1'b1;
      end
    end
  end

  // Registered strobe and code per channel
  for (genvar i = 0; i < `DAC_NUM_CHANNELS; i++) begin : g_chan
    always_ff @(posedge sclk) begin
      if (reset) begin
        chan[i].load <= 1'b0;
      end else begin
        chan[i].load <= chan_sel[i];
      end
    end

    // Code only changes when this channel is written
    always_ff @(posedge sclk) begin
      if (chan_sel[i]) begin
        chan[i].code <= write_code;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/dac_channel.sv
`default_nettype none

`include "dac_macros.svh"

module dac_channel
  import dac_pkg::*;
(
  input  wire logic sclk,
  input  wire logic reset,
  dac_chan_if.chan  bus,
  output logic      dac_din,
  output logic      nsync,
  output logic      nldac
);

  localparam logic [3:0] LAST_BIT = 4'(`DAC_FRAME_BITS - 1);

  dac_state_e state;
  dac_state_e state_next;
  logic       frame_start;

  // Latest code from the host, waiting for the serial side
  logic       pending_valid;
  dac_code_t  pending_code;

  dac_code_t  shift_reg;
  dac_code_t  frame_code;
  dac_code_t  last_code;
  logic [3:0] bit_count;

  // Framing sequence
  always_comb begin
    state_next  = state;
    frame_start = 1'b0;
    case (state)
      IDLE: begin
        if (pending_valid) begin
          state_next  = SHIFT;
          frame_start = 1'b1;
        end
      end
      SHIFT: begin
        // Last bit on the wire this cycle
        if (bit_count == LAST_BIT) begin
          state_next = LDAC;
        end
      end
      LDAC: begin
        state_next = IDLE;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge sclk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // A new load wins over the frame start that consumes the old one
  always_ff @(posedge sclk) begin
    if (reset) begin
      pending_valid <= 1'b0;
    end else if (bus.load) begin
      pending_valid <= 1'b1;
    end else if (frame_start) begin
      pending_valid <= 1'b0;
    end
  end

  always_ff @(posedge sclk) begin
    if (bus.load) begin
      pending_code <= bus.code;
    end
  end

  // Copy of the code in flight, for last_code
  always_ff @(posedge sclk) begin
    if (frame_start) begin
      frame_code <= pending_code;
    end
  end

  // MSB first, zeros shift in behind
  always_ff @(posedge sclk) begin
    if (reset) begin
      shift_reg <= '0;
    end else if (frame_start) begin
      shift_reg <= pending_code;
    end else if (state == SHIFT) begin
      shift_reg <= {shift_reg[`DAC_FRAME_BITS-2:0], 1'b0};
    end
  end

  always_ff @(posedge sclk) begin
    if (reset) begin
      bit_count <= '0;
    end else if (state == SHIFT) begin
      bit_count <= bit_count + 4'd1;
    end else begin
      bit_count <= '0;
    end
  end

  // Frame counts as sent once the load pulse is done
  always_ff @(posedge sclk) begin
    if (reset) begin
      last_code <= '0;
    end else if (state == LDAC) begin
      last_code <= frame_code;
    end
  end

  assign dac_din = shift_reg[`DAC_FRAME_BITS-1];
  assign nsync   = (state != SHIFT);
  assign nldac   = (state != LDAC);

  assign bus.busy      = bus.load || pending_valid || (state != IDLE);
  assign bus.last_code = last_code;

endmodule

`default_nettype wire

//--- rtl/readback_mux.sv
`default_nettype none

`include "dac_macros.svh"

module readback_mux
  import dac_pkg::*;
(
  input  wire logic        sclk,
  input  wire logic        reset,
  input  wire logic        cmd_bus_enable,
  input  wire logic        re,
  input  wire logic [15:0] cmd_bus_addr,
  dac_chan_if.mon          chan [`DAC_NUM_CHANNELS],
  output logic      [15:0] out_data
);

  logic                         cs;
  logic [7:0]                   offset;
  logic [`DAC_NUM_CHANNELS-1:0] busy_vec;
  dac_code_t                    last_codes [`DAC_NUM_CHANNELS];
  logic [15:0]                  read_value;

  assign cs     = cmd_bus_enable && (cmd_bus_addr[15:8] == `DAC_POSITION);
  assign offset = cmd_bus_addr[7:0];

  // Gather channel status
  for (genvar i = 0; i < `DAC_NUM_CHANNELS; i++) begin : g_mon
    assign busy_vec[i]   = chan[i].busy;
    assign last_codes[i] = chan[i].last_code;
  end

  // Undefined offsets fall through as zero
  always_comb begin
    read_value = 16'h0000;
    if (offset == `DAC_REG_ID) begin
      read_value = `DAC_ID_WORD;
    end else if (offset == `DAC_REG_BUSY) begin
      read_value = 16'(busy_vec);
    end else begin
      for (int i = 0; i < `DAC_NUM_CHANNELS; i++) begin
        if (offset == (`DAC_REG_LAST_BASE + 8'(i))) begin
          read_value = last_codes[i];
        end
      end
    end
  end

  // Zero whenever there is no read this edge
  always_ff @(posedge sclk) begin
    if (reset) begin
      out_data <= 16'h0000;
    end else if (cs && re) begin
      out_data <= read_value;
    end else begin
      out_data <= 16'h0000;
    end
  end

endmodule

`default_nettype wire

//--- rtl/dac_subsystem.sv
`default_nettype none

`include "dac_macros.svh"

module dac_subsystem (
  input  wire logic                         sclk,
  input  wire logic                         reset,

  // Host command bus
  input  wire logic                         cmd_bus_enable,
  input  wire logic                         cmd_bus_wr,
  input  wire logic                         re,
  input  wire logic [15:0]                  cmd_bus_addr,
  input  wire logic [31:0]                  cmd_bus_data,
  output logic      [15:0]                  out_data,

  // Serial DAC pins, one bit per channel
  output logic      [`DAC_NUM_CHANNELS-1:0] dac_din,
  output logic      [`DAC_NUM_CHANNELS-1:0] dac_nsync,
  output logic      [`DAC_NUM_CHANNELS-1:0] dac_nldac
);

  // One link per channel between decoder, channel and mux
  dac_chan_if chan_if [`DAC_NUM_CHANNELS] ();

  cmd_decoder u_cmd_decoder (
    .sclk           (sclk),
    .reset          (reset),
    .cmd_bus_enable (cmd_bus_enable),
    .cmd_bus_wr     (cmd_bus_wr),
    .cmd_bus_addr   (cmd_bus_addr),
    .cmd_bus_data   (cmd_bus_data),
    .chan           (chan_if)
  );

  // Identical channel controllers
  for (genvar i = 0; i < `DAC_NUM_CHANNELS; i++) begin : g_channel
    dac_channel u_dac_channel (
      .sclk    (sclk),
      .reset   (reset),
      .bus     (chan_if[i]),
      .dac_din (dac_din[i]),
      .nsync   (dac_nsync[i]),
      .nldac   (dac_nldac[i])
    );
  end

  readback_mux u_readback_mux (
    .sclk           (sclk),
    .reset          (reset),
    .cmd_bus_enable (cmd_bus_enable),
    .re             (re),
    .cmd_bus_addr   (cmd_bus_addr),
    .chan           (chan_if),
    .out_data       (out_data)
  );

endmodule

`default_nettype wire

//--- testbench/dac_props.sv
`default_nettype none

`include "dac_macros.svh"

module dac_props (
  input wire logic                         sclk,
  input wire logic                         reset,
  input wire logic                         cmd_bus_enable,
  input wire logic                         re,
  input wire logic [15:0]                  cmd_bus_addr,
  input wire logic [15:0]                  out_data,
  input wire logic [`DAC_NUM_CHANNELS-1:0] dac_nsync,
  input wire logic [`DAC_NUM_CHANNELS-1:0] dac_nldac
);
  timeunit 1ns;
  timeprecision 100ps;

  logic read_hit;

  assign read_hit = cmd_bus_enable && re && (cmd_bus_addr[15:8] == `DAC_POSITION);

  for (genvar i = 0; i < `DAC_NUM_CHANNELS; i++) begin : g_frame
    // Length of the current sync low period
    logic [4:0] low_cycles;

    always_ff @(posedge sclk) begin
      if (reset || dac_nsync[i]) begin
        low_cycles <= '0;
      end else begin
        low_cycles <= low_cycles + 5'd1;
      end
    end

    sync_length: assert property (@(posedge sclk) disable iff (reset)
      $rose(dac_nsync[i]) |-> (low_cycles == 5'(`DAC_FRAME_BITS)))
      else $error("channel %0d sync was low for %0d cycles", i, low_cycles);

    sync_bounded: assert property (@(posedge sclk) disable iff (reset)
      low_cycles <= 5'(`DAC_FRAME_BITS))
      else $error("channel %0d sync stays low past the frame", i);

    // Load pulse exactly in the cycle after sync goes high
    ldac_slot: assert property (@(posedge sclk) disable iff (reset)
      (!dac_nldac[i]) == $rose(dac_nsync[i]))
      else $error("channel %0d load pulse out of place", i);
  end

  read_idle_zero: assert property (@(posedge sclk) disable iff (reset)
    !read_hit |=> (out_data == 16'h0000))
    else $error("read data not zero after an edge without a read");

endmodule

bind dac_subsystem dac_props u_dac_props (
  .sclk           (sclk),
  .reset          (reset),
  .cmd_bus_enable (cmd_bus_enable),
  .re             (re),
  .cmd_bus_addr   (cmd_bus_addr),
  .out_data       (out_data),
  .dac_nsync      (dac_nsync),
  .dac_nldac      (dac_nldac)
);

`default_nettype wire

//--- testbench/dac_tb.sv
`default_nettype none

`include "dac_macros.svh"

module dac_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CH     = `DAC_NUM_CHANNELS;
  localparam int LOG_DEPTH  = 8;
  localparam int WAIT_LIMIT = 200;
  localparam logic [15:0] BUSY_ADDR = {`DAC_POSITION, `DAC_REG_BUSY};

  logic              sclk;
  logic              reset;
  logic              cmd_bus_enable;
  logic              cmd_bus_wr;
  logic              re;
  logic [15:0]       cmd_bus_addr;
  logic [31:0]       cmd_bus_data;
  logic [15:0]       out_data;
  logic [NUM_CH-1:0] dac_din;
  logic [NUM_CH-1:0] dac_nsync;
  logic [NUM_CH-1:0] dac_nldac;

  // Captured serial frames per channel
  logic [15:0] shift_acc [NUM_CH];
  int          bit_cnt [NUM_CH];
  logic [15:0] frame_log [NUM_CH][LOG_DEPTH];
  int          frame_wr [NUM_CH];
  int          frame_rd [NUM_CH];

  dac_subsystem uut (
    .sclk           (sclk),
    .reset          (reset),
    .cmd_bus_enable (cmd_bus_enable),
    .cmd_bus_wr     (cmd_bus_wr),
    .re             (re),
    .cmd_bus_addr   (cmd_bus_addr),
    .cmd_bus_data   (cmd_bus_data),
    .out_data       (out_data),
    .dac_din        (dac_din),
    .dac_nsync      (dac_nsync),
    .dac_nldac      (dac_nldac)
  );

  initial begin
    sclk = 1'b0;
    forever #10 sclk = ~sclk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual));
    end
  endtask

  task automatic store_frame(input int ch);
    check_value($sformatf("frame length on channel %0d", ch), `DAC_FRAME_BITS, bit_cnt[ch]);
    if (frame_wr[ch] >= LOG_DEPTH) begin
      abort_run($sformatf("Too many frames captured on channel %0d", ch));
    end else begin
      frame_log[ch][frame_wr[ch]] = shift_acc[ch];
      frame_wr[ch] = frame_wr[ch] + 1;
      bit_cnt[ch]  = 0;
      shift_acc[ch] = '0;
    end
  endtask

  // Sample the pins mid-cycle, away from the clock edge
  always @(negedge sclk) begin
    for (int c = 0; c < NUM_CH; c++) begin
      if (reset) begin
        shift_acc[c] = '0;
        bit_cnt[c]   = 0;
        frame_wr[c]  = 0;
      end else begin
        if (!dac_nsync[c]) begin
          shift_acc[c] = {shift_acc[c][14:0], dac_din[c]};
          bit_cnt[c]   = bit_cnt[c] + 1;
        end
        if (!dac_nldac[c]) begin
          store_frame(c);
        end
      end
    end
  end

  // Bus tasks start and end 2 ns after a rising edge
  task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
    cmd_bus_enable = 1'b1;
    cmd_bus_wr     = 1'b1;
    cmd_bus_addr   = addr;
    cmd_bus_data   = data;
    @(posedge sclk);
    #2;
    cmd_bus_enable = 1'b0;
    cmd_bus_wr     = 1'b0;
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [15:0] value);
    cmd_bus_enable = 1'b1;
    re             = 1'b1;
    cmd_bus_addr   = addr;
    @(posedge sclk);
    #2;
    cmd_bus_enable = 1'b0;
    re             = 1'b0;
    value          = out_data;
  endtask

  // Poll the busy register until every channel is done
  task automatic wait_idle(input string name);
    logic [15:0] busy;
    int          cycles;
    busy   = 16'hffff;
    cycles = 0;
    while ((busy != 16'h0000) && (cycles < WAIT_LIMIT)) begin
      bus_read(BUSY_ADDR, busy);
      cycles++;
    end
    if (busy != 16'h0000) begin
      abort_run($sformatf("%s: channels still busy after %0d cycles", name, WAIT_LIMIT));
    end
  endtask

  task automatic check_frame(input string name, input int ch, input logic [31:0] expected);
    int cycles;
    cycles = 0;
    while ((frame_rd[ch] >= frame_wr[ch]) && (cycles < WAIT_LIMIT)) begin
      @(posedge sclk);
      #2;
      cycles++;
    end
    if (frame_rd[ch] >= frame_wr[ch]) begin
      abort_run($sformatf("%s: no frame arrived on channel %0d", name, ch));
    end else begin
      check_value(name, expected, {16'h0000, frame_log[ch][frame_rd[ch]]});
      frame_rd[ch] = frame_rd[ch] + 1;
    end
  endtask

  task automatic check_quiet(input string name);
    for (int c = 0; c < NUM_CH; c++) begin
      if (frame_rd[c] != frame_wr[c]) begin
        abort_run($sformatf("%s: channel %0d sent a frame it was not written", name, c));
      end
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          step;
    string       op;
    string       line;
    string       name;
    logic [15:0] addr;
    logic [15:0] value;
    logic [31:0] data;
    logic [31:0] expected;

    reset          = 1'b1;
    cmd_bus_enable = 1'b0;
    cmd_bus_wr     = 1'b0;
    re             = 1'b0;
    cmd_bus_addr   = '0;
    cmd_bus_data   = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      frame_rd[c] = 0;
    end
    step = 0;

    repeat (5) @(posedge sclk);
    #2;
    reset = 1'b0;

    fd = $fopen("testbench/dac_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open testbench/dac_patterns.txt");
    end

    while ($fscanf(fd, "%s", op) == 1) begin
      if (op.substr(0, 0) == "#") begin
        n = $fgets(line, fd);
      end else begin
        n = $fscanf(fd, "%h %h %h", addr, data, expected);
        step++;
        name = $sformatf("step %0d %s %h", step, op, addr);
        if (n != 3) begin
          abort_run($sformatf("Pattern line for %s is incomplete", name));
        end else if (op == "write") begin
          bus_write(addr, data);
        end else if (op == "read") begin
          bus_read(addr, value);
          check_value(name, expected, {16'h0000, value});
        end else if (op == "idle") begin
          wait_idle(name);
        end else if (op == "frame") begin
          if (addr >= 16'(NUM_CH)) begin
            abort_run($sformatf("%s names a channel that does not exist", name));
          end else begin
            check_frame(name, int'(addr), expected);
          end
        end else if (op == "quiet") begin
          check_quiet(name);
        end else begin
          abort_run($sformatf("Unknown operation %s in the pattern file", op));
        end
      end
    end
    $fclose(fd);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
rtl/dac_pkg.sv
rtl/dac_chan_if.sv
rtl/cmd_decoder.sv
rtl/dac_channel.sv
rtl/readback_mux.sv
rtl/dac_subsystem.sv
testbench/dac_props.sv
testbench/dac_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module dac_tb \
  -o dac_tb_sim || { echo "Verilator build failed"; exit 1; }

sim_output=$(./obj_dir/dac_tb_sim 2>&1)
echo "$sim_output"

echo "$sim_output" | grep -q "^RESULT: PASS$" && exit 0 || exit 1

//--- testbench/dac_patterns.txt
# op addr data expected, numbers in hex
# frame: addr is the channel, quiet: no frames left unchecked
read  f00a 00000000 0000
read  f009 00000000 0dac
read  e009 00000000 0000
read  f00b 00000000 0000
# single write to channel 1
write f001 0001a5c3 0
read  f00a 00000000 0002
idle  0 0 0
read  f00a 00000000 0000
frame 1 0 a5c3
quiet 0 0 0
read  f011 00000000 a5c3
# all four channels back to back
write f000 00011111 0
write f001 00012222 0
write f002 00013333 0
write f003 00014444 0
idle  0 0 0
frame 0 0 1111
frame 1 0 2222
frame 2 0 3333
frame 3 0 4444
quiet 0 0 0
read  f010 00000000 1111
read  f013 00000000 4444
# NOP, channel out of range, other position, unknown opcode
write f002 00005555 0
write f004 00016666 0
write e001 00017777 0
write f001 00027777 0
idle  0 0 0
quiet 0 0 0
read  f010 00000000 1111
read  f011 00000000 2222
read  f012 00000000 3333
read  f013 00000000 4444
# three writes to channel 2 while its frame runs
write f002 0001abcd 0
write f002 00011234 0
write f002 0001beef 0
idle  0 0 0
frame 2 0 abcd
frame 2 0 beef
quiet 0 0 0
read  f012 00000000 beef
